// File: common/sys_pkg.sv
package sys_pkg;

	// ===================================================================
	// Data path widths
	// ===================================================================

	// Audio sample and internal arithmetic, one guard bit
	localparam int SAMPLE_W = 16;
	localparam int ACC_W    = SAMPLE_W + 1;

	// Host data word
	localparam int IO_W = 16;

	// Volume: top bit mutes, low bits give the attenuation shift
	localparam int VOL_W = 5;

	// Sync phase-length counters
	localparam int SYNC_CNT_W = 16;

	// ===================================================================
	// Configuration word layout
	// ===================================================================

	localparam int CFG_CSYNC_BIT = 3;

	// ===================================================================
	// Enumerations
	// ===================================================================

	// Host commands, other values ignored
	typedef enum logic [7:0] {
		CMD_CFG = 8'h01,
		CMD_LED = 8'h25,
		CMD_VOL = 8'h26
	} cmd_e;

	// Stereo cross-mix amount
	typedef enum logic [1:0] {
		MIX_NONE    = 2'd0,
		MIX_EIGHTH  = 2'd1,
		MIX_QUARTER = 2'd2,
		MIX_HALF    = 2'd3
	} mix_e;

endpackage

// File: hw/cmd_decoder.sv
`timescale 1ns/1ns

module cmd_decoder import sys_pkg::*; (
	input  logic             clk_sys,
	input  logic             resetd,
	input  logic             i_io_uio,
	input  logic             i_io_clk,
	input  logic [IO_W-1:0]  i_io_din,
	output logic             o_csync,
	output logic [VOL_W-1:0] o_vol,
	output logic             o_led_wr,
	output logic [IO_W-1:0]  o_io_data
);

	logic            strb_s1;
	logic            strb_s2;
	logic            strb_s3;
	logic            strb_rise;
	logic            has_cmd;
	cmd_e            cmd;
	logic            word_vld;
	logic [IO_W-1:0] word;
	logic [IO_W-1:0] cfg;

	// ===================================================================
	// Strobe synchroniser and rising edge detect
	// ===================================================================

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			strb_s1 <= 1'b0;
			strb_s2 <= 1'b0;
			strb_s3 <= 1'b0;
		end else begin
			strb_s1 <= i_io_clk;
			strb_s2 <= strb_s1;
			strb_s3 <= strb_s2;
		end
	end

	assign strb_rise = strb_s2 & ~strb_s3;

	// ===================================================================
	// First word is the command and later words are data
	// ===================================================================

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			has_cmd  <= 1'b0;
			word_vld <= 1'b0;
		end else begin
			word_vld <= 1'b0;
			if (!i_io_uio) begin
				has_cmd <= 1'b0;
			end else if (strb_rise) begin
				if (!has_cmd) begin
					has_cmd <= 1'b1;
				end else begin
					word_vld <= 1'b1;
				end
			end
		end
	end

	// Command code and data word latched on each strobe
	always_ff @(posedge clk_sys) begin
		if (i_io_uio && strb_rise) begin
			if (!has_cmd) begin
				cmd <= cmd_e'(i_io_din[7:0]);
			end else begin
				word <= i_io_din;
			end
		end
	end

	// ===================================================================
	// Registers loaded by data words
	// ===================================================================

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			cfg   <= '0;
			o_vol <= '0;
		end else if (word_vld) begin
			case (cmd)
				CMD_CFG: cfg <= word;
				CMD_VOL: o_vol <= word[VOL_W-1:0];
				default: ;
			endcase
		end
	end

	assign o_csync = cfg[CFG_CSYNC_BIT];

	// LED block loads in the same cycle as the other registers
	assign o_led_wr  = word_vld && (cmd == CMD_LED);
	assign o_io_data = word;

endmodule

// File: audio_mix/audio_mixer.sv
`timescale 1ns/1ns

module audio_mixer import sys_pkg::*; (
	input  logic                clk_sys,
	input  logic                resetd,
	input  logic [SAMPLE_W-1:0] i_core_l,
	input  logic [SAMPLE_W-1:0] i_core_r,
	input  logic [SAMPLE_W-1:0] i_pcm_l,
	input  logic [SAMPLE_W-1:0] i_pcm_r,
	input  logic                i_core_signed,
	input  mix_e                i_mix,
	input  logic [VOL_W-1:0]    i_vol,
	output logic [SAMPLE_W-1:0] o_audio_l,
	output logic [SAMPLE_W-1:0] o_audio_r
);

	localparam logic signed [ACC_W-1:0] SAT_MAX = ACC_W'((1 << (SAMPLE_W-1)) - 1);
	localparam logic signed [ACC_W-1:0] SAT_MIN = ACC_W'(-(1 << (SAMPLE_W-1)));

	logic signed [ACC_W-1:0] s1_core_l;
	logic signed [ACC_W-1:0] s1_core_r;
	logic signed [ACC_W-1:0] s1_pcm_l;
	logic signed [ACC_W-1:0] s1_pcm_r;
	logic signed [ACC_W-1:0] sum_l;
	logic signed [ACC_W-1:0] sum_r;
	logic signed [ACC_W-1:0] mix_l;
	logic signed [ACC_W-1:0] mix_r;
	logic signed [ACC_W-1:0] s2_l;
	logic signed [ACC_W-1:0] s2_r;
	logic signed [ACC_W-1:0] s3_l;
	logic signed [ACC_W-1:0] s3_r;

	function automatic logic [SAMPLE_W-1:0] clamp(input logic signed [ACC_W-1:0] v);
		if (v > SAT_MAX) begin
			return SAT_MAX[SAMPLE_W-1:0];
		end else if (v < SAT_MIN) begin
			return SAT_MIN[SAMPLE_W-1:0];
		end
		return v[SAMPLE_W-1:0];
	endfunction

	// Source sum and cross-mix for stage 2
	always_comb begin
		sum_l = s1_core_l + s1_pcm_l;
		sum_r = s1_core_r + s1_pcm_r;
		case (i_mix)
			MIX_EIGHTH: begin
				mix_l = sum_l - (sum_l >>> 3) + (sum_r >>> 3);
				mix_r = sum_r - (sum_r >>> 3) + (sum_l >>> 3);
			end
			MIX_QUARTER: begin
				mix_l = sum_l - (sum_l >>> 2) + (sum_r >>> 2);
				mix_r = sum_r - (sum_r >>> 2) + (sum_l >>> 2);
			end
			MIX_HALF: begin
				mix_l = (sum_l >>> 1) + (sum_r >>> 1);
				mix_r = (sum_r >>> 1) + (sum_l >>> 1);
			end
			default: begin
				mix_l = sum_l;
				mix_r = sum_r;
			end
		endcase
	end

	// ===================================================================
	// Four-stage pipeline
	// ===================================================================

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			s1_core_l <= '0;
			s1_core_r <= '0;
			s1_pcm_l  <= '0;
			s1_pcm_r  <= '0;
			s2_l      <= '0;
			s2_r      <= '0;
			s3_l      <= '0;
			s3_r      <= '0;
			o_audio_l <= '0;
			o_audio_r <= '0;
		end else begin
			// Stage 1, unsigned core audio halved to keep it non-negative
			if (i_core_signed) begin
				s1_core_l <= {i_core_l[SAMPLE_W-1], i_core_l};
				s1_core_r <= {i_core_r[SAMPLE_W-1], i_core_r};
			end else begin
				s1_core_l <= {2'b00, i_core_l[SAMPLE_W-1:1]};
				s1_core_r <= {2'b00, i_core_r[SAMPLE_W-1:1]};
			end
			s1_pcm_l <= {i_pcm_l[SAMPLE_W-1], i_pcm_l};
			s1_pcm_r <= {i_pcm_r[SAMPLE_W-1], i_pcm_r};

			// Stage 2
			s2_l <= mix_l;
			s2_r <= mix_r;

			// Stage 3, attenuation or mute
			if (i_vol[VOL_W-1]) begin
				s3_l <= '0;
				s3_r <= '0;
			end else begin
				s3_l <= s2_l >>> i_vol[VOL_W-2:0];
				s3_r <= s2_r >>> i_vol[VOL_W-2:0];
			end

			// Stage 4
			o_audio_l <= clamp(s3_l);
			o_audio_r <= clamp(s3_r);
		end
	end

endmodule

// File: hw/sync_polarity.sv
`timescale 1ns/1ns

module sync_polarity import sys_pkg::*; (
	input  logic clk_sys,
	input  logic resetd,
	input  logic i_sync,
	output logic o_sync
);

	logic                  sync_d;
	logic [SYNC_CNT_W-1:0] cnt;
	logic [SYNC_CNT_W-1:0] hi_len;
	logic [SYNC_CNT_W-1:0] lo_len;
	logic                  pol;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			sync_d <= 1'b0;
			cnt    <= '0;
			hi_len <= '0;
			lo_len <= '0;
			pol    <= 1'b0;
		end else begin
			sync_d <= i_sync;
			if (i_sync != sync_d) begin
				// Phase just ended, keep its length
				if (sync_d) begin
					hi_len <= cnt;
				end else begin
					lo_len <= cnt;
				end
				cnt <= '0;
			end else if (cnt != '1) begin
				cnt <= cnt + 1'b1;
			end
			pol <= hi_len > lo_len;
		end
	end

	// Longer high phase means an active-low pulse
	assign o_sync = i_sync ^ pol;

endmodule

// File: hw/vga_sync.sv
`timescale 1ns/1ns

module vga_sync (
	input  logic clk_sys,
	input  logic resetd,
	input  logic i_hs,
	input  logic i_vs,
	input  logic i_csync,
	output logic o_vga_hs,
	output logic o_vga_vs
);

	logic hs_pos;
	logic vs_pos;

	sync_polarity u_hs_pol (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_sync  (i_hs),
		.o_sync  (hs_pos)
	);

	sync_polarity u_vs_pol (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_sync  (i_vs),
		.o_sync  (vs_pos)
	);

	// ===================================================================
	// Active-low output, composite on HS when enabled
	// ===================================================================

	assign o_vga_hs = i_csync ? ~(hs_pos ^ vs_pos) : ~hs_pos;
	assign o_vga_vs = i_csync ? 1'b1 : ~vs_pos;

endmodule

// File: hw/button_debounce.sv
`timescale 1ns/1ns

module button_debounce #(
	parameter int DEB_DIV = 100000
) (
	input  logic clk_sys,
	input  logic resetd,
	input  logic i_btn_user_n,
	input  logic i_btn_osd_n,
	output logic o_btn_user,
	output logic o_btn_osd
);

	localparam int DIV_W = $clog2(DEB_DIV + 1);

	logic [DIV_W-1:0] div_cnt;
	logic             tick;
	logic [1:0]       btn_n;
	logic [7:0]       hist [2];
	logic [7:0]       hist_nxt [2];
	logic [1:0]       btn_q;

	// Tick divider
	always_ff @(posedge clk_sys) begin
		if (resetd || tick) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	assign tick = div_cnt == DIV_W'(DEB_DIV - 1);

	// Index 0 user, index 1 OSD
	assign btn_n = {i_btn_osd_n, i_btn_user_n};

	always_comb begin
		for (int i = 0; i < 2; i++) begin
			hist_nxt[i] = {hist[i][6:0], ~btn_n[i]};
		end
	end

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			hist[0] <= '0;
			hist[1] <= '0;
			btn_q   <= '0;
		end else if (tick) begin
			for (int i = 0; i < 2; i++) begin
				hist[i] <= hist_nxt[i];
				// Output moves only on eight equal samples
				if (&hist_nxt[i]) begin
					btn_q[i] <= 1'b1;
				end else if (hist_nxt[i] == '0) begin
					btn_q[i] <= 1'b0;
				end
			end
		end
	end

	assign o_btn_user = btn_q[0];
	assign o_btn_osd  = btn_q[1];

endmodule

// File: hw/led_ctrl.sv
`timescale 1ns/1ns

module led_ctrl import sys_pkg::*; (
	input  logic            clk_sys,
	input  logic            resetd,
	input  logic            i_led_wr,
	input  logic [IO_W-1:0] i_io_data,
	input  logic            i_led_user,
	input  logic [1:0]      i_led_power,
	input  logic [1:0]      i_led_disk,
	output logic            o_lamp_user,
	output logic            o_lamp_power,
	output logic            o_lamp_disk,
	output logic [7:0]      o_led
);

	logic [7:0] led_ovr;
	logic [7:0] led_state;
	logic [7:0] led_map;

	// High byte is the override mask, low byte the forced state
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			led_ovr   <= '0;
			led_state <= '0;
		end else if (i_led_wr) begin
			{led_ovr, led_state} <= i_io_data;
		end
	end

	assign o_lamp_user  = i_led_user;
	// Disk lamp needs only the request bit
	assign o_lamp_disk  = i_led_disk[0];
	assign o_lamp_power = i_led_power[1] ? i_led_power[0] : 1'b1;

	assign led_map = {3'b000, o_lamp_power, 1'b0, o_lamp_disk, 1'b0, o_lamp_user};
	assign o_led   = (led_ovr & led_state) | (~led_ovr & led_map);

endmodule

// File: hw/sys_core.sv
`timescale 1ns/1ns

module sys_core import sys_pkg::*; #(
	parameter int DEB_DIV = 100000
) (
	input  logic                clk_sys,
	input  logic                resetd,
	// Host channel
	input  logic                i_io_uio,
	input  logic                i_io_clk,
	input  logic [IO_W-1:0]     i_io_din,
	// Audio sources
	input  logic [SAMPLE_W-1:0] i_core_l,
	input  logic [SAMPLE_W-1:0] i_core_r,
	input  logic [SAMPLE_W-1:0] i_pcm_l,
	input  logic [SAMPLE_W-1:0] i_pcm_r,
	input  logic                i_core_signed,
	input  mix_e                i_mix,
	// Video sync from the core
	input  logic                i_hs,
	input  logic                i_vs,
	// LED requests and buttons
	input  logic                i_led_user,
	input  logic [1:0]          i_led_power,
	input  logic [1:0]          i_led_disk,
	input  logic                i_btn_user_n,
	input  logic                i_btn_osd_n,
	output logic [SAMPLE_W-1:0] o_audio_l,
	output logic [SAMPLE_W-1:0] o_audio_r,
	output logic                o_vga_hs,
	output logic                o_vga_vs,
	output logic                o_lamp_user,
	output logic                o_lamp_power,
	output logic                o_lamp_disk,
	output logic [7:0]          o_led,
	output logic                o_btn_user,
	output logic                o_btn_osd
);

	logic             csync;
	logic [VOL_W-1:0] vol;
	logic             led_wr;
	logic [IO_W-1:0]  io_data;

	// ===================================================================
	// Host commands
	// ===================================================================

	cmd_decoder u_cmd_decoder (
		.clk_sys   (clk_sys),
		.resetd    (resetd),
		.i_io_uio  (i_io_uio),
		.i_io_clk  (i_io_clk),
		.i_io_din  (i_io_din),
		.o_csync   (csync),
		.o_vol     (vol),
		.o_led_wr  (led_wr),
		.o_io_data (io_data)
	);

	// ===================================================================
	// Audio, video sync, buttons and LEDs
	// ===================================================================

	audio_mixer u_audio_mixer (
		.clk_sys       (clk_sys),
		.resetd        (resetd),
		.i_core_l      (i_core_l),
		.i_core_r      (i_core_r),
		.i_pcm_l       (i_pcm_l),
		.i_pcm_r       (i_pcm_r),
		.i_core_signed (i_core_signed),
		.i_mix         (i_mix),
		.i_vol         (vol),
		.o_audio_l     (o_audio_l),
		.o_audio_r     (o_audio_r)
	);

	vga_sync u_vga_sync (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_hs     (i_hs),
		.i_vs     (i_vs),
		.i_csync  (csync),
		.o_vga_hs (o_vga_hs),
		.o_vga_vs (o_vga_vs)
	);

	button_debounce #(
		.DEB_DIV (DEB_DIV)
	) u_button_debounce (
		.clk_sys      (clk_sys),
		.resetd       (resetd),
		.i_btn_user_n (i_btn_user_n),
		.i_btn_osd_n  (i_btn_osd_n),
		.o_btn_user   (o_btn_user),
		.o_btn_osd    (o_btn_osd)
	);

	led_ctrl u_led_ctrl (
		.clk_sys      (clk_sys),
		.resetd       (resetd),
		.i_led_wr     (led_wr),
		.i_io_data    (io_data),
		.i_led_user   (i_led_user),
		.i_led_power  (i_led_power),
		.i_led_disk   (i_led_disk),
		.o_lamp_user  (o_lamp_user),
		.o_lamp_power (o_lamp_power),
		.o_lamp_disk  (o_lamp_disk),
		.o_led        (o_led)
	);

endmodule

// File: tests/tb_sys_core.sv
`timescale 1ns/1ns

module tb_sys_core import sys_pkg::*; ();

	logic                clk_sys;
	logic                resetd;
	logic                i_io_uio;
	logic                i_io_clk;
	logic [IO_W-1:0]     i_io_din;
	logic [SAMPLE_W-1:0] i_core_l;
	logic [SAMPLE_W-1:0] i_core_r;
	logic [SAMPLE_W-1:0] i_pcm_l;
	logic [SAMPLE_W-1:0] i_pcm_r;
	logic                i_core_signed;
	mix_e                i_mix;
	logic                i_hs;
	logic                i_vs;
	logic                i_led_user;
	logic [1:0]          i_led_power;
	logic [1:0]          i_led_disk;
	logic                i_btn_user_n;
	logic                i_btn_osd_n;
	logic [SAMPLE_W-1:0] o_audio_l;
	logic [SAMPLE_W-1:0] o_audio_r;
	logic                o_vga_hs;
	logic                o_vga_vs;
	logic                o_lamp_user;
	logic                o_lamp_power;
	logic                o_lamp_disk;
	logic [7:0]          o_led;
	logic                o_btn_user;
	logic                o_btn_osd;

	// Expected register state as the host has set it
	logic [VOL_W-1:0] exp_vol;
	logic [7:0]       exp_ovr;
	logic [7:0]       exp_st;
	logic             exp_csync;
	bit               chk_en;
	bit               sync_chk;
	int               sync_good;
	int               checks;
	int               errors;
	int               timeouts;
	integer           seed;
	// Entries are {valid, left, right}
	logic [32:0]      aq [$];

	sys_core #(.DEB_DIV(4)) u_dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// ===================================================================
	// Reference models
	// ===================================================================

	function automatic logic [31:0] audio_ref(input logic [15:0] cl, input logic [15:0] cr,
			input logic [15:0] pl, input logic [15:0] pr, input logic sgn,
			input mix_e mix, input logic [VOL_W-1:0] vol);
		int l;
		int r;
		int ml;
		int mr;
		l = (sgn ? int'($signed(cl)) : int'(cl >> 1)) + int'($signed(pl));
		r = (sgn ? int'($signed(cr)) : int'(cr >> 1)) + int'($signed(pr));
		case (mix)
			MIX_EIGHTH: begin
				ml = l - (l >>> 3) + (r >>> 3);
				mr = r - (r >>> 3) + (l >>> 3);
			end
			MIX_QUARTER: begin
				ml = l - (l >>> 2) + (r >>> 2);
				mr = r - (r >>> 2) + (l >>> 2);
			end
			MIX_HALF: begin
				ml = (l >>> 1) + (r >>> 1);
				mr = ml;
			end
			default: begin
				ml = l;
				mr = r;
			end
		endcase
		ml = vol[VOL_W-1] ? 0 : ml >>> vol[VOL_W-2:0];
		mr = vol[VOL_W-1] ? 0 : mr >>> vol[VOL_W-2:0];
		// Clamp to signed 16 bits
		ml = (ml > 32767) ? 32767 : ((ml < -32768) ? -32768 : ml);
		mr = (mr > 32767) ? 32767 : ((mr < -32768) ? -32768 : mr);
		return {ml[15:0], mr[15:0]};
	endfunction

	// Result is {user, power, disk, board LEDs}
	function automatic logic [10:0] led_ref(input logic user, input logic [1:0] pwr,
			input logic [1:0] dsk, input logic [7:0] ovr, input logic [7:0] st);
		logic       lp;
		logic [7:0] map;
		lp = pwr[1] ? pwr[0] : 1'b1;
		map = 8'h00;
		map[0] = user;
		map[2] = dsk[0];
		map[4] = lp;
		return {user, lp, dsk[0], (map & ~ovr) | (st & ovr)};
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("[FAIL] %s got %h expected %h", name, got, exp);
		end
	endtask

	// ===================================================================
	// Audio pipeline monitor
	// ===================================================================

	always @(posedge clk_sys) begin
		if (!resetd) begin
			aq.push_back({chk_en, audio_ref(i_core_l, i_core_r, i_pcm_l, i_pcm_r,
				i_core_signed, i_mix, exp_vol)});
		end
	end

	// Four posedges after capture the pair is on the outputs
	always @(negedge clk_sys) begin : audio_cmp
		logic [32:0] e;
		if (aq.size() == 4) begin
			e = aq.pop_front();
			if (e[32]) begin
				check_value("o_audio_l", 32'(o_audio_l), 32'(e[31:16]));
				check_value("o_audio_r", 32'(o_audio_r), 32'(e[15:0]));
			end
		end
	end

	// Active-low HS and VS generator that compares before each new drive
	initial begin : sync_gen
		int   ph_h;
		int   ph_v;
		logic exp_hs;
		logic exp_vs;
		logic last_csync;
		ph_h = 0;
		ph_v = 0;
		i_hs = 1'b0;
		i_vs = 1'b0;
		last_csync = 1'b0;
		forever begin
			@(negedge clk_sys);
			exp_hs = exp_csync ? ~(i_hs ^ i_vs) : i_hs;
			exp_vs = exp_csync | i_vs;
			if (exp_csync != last_csync || o_vga_hs !== exp_hs || o_vga_vs !== exp_vs) begin
				sync_good = 0;
			end else begin
				sync_good++;
			end
			last_csync = exp_csync;
			if (sync_chk) begin
				check_value("o_vga_hs", 32'(o_vga_hs), 32'(exp_hs));
				check_value("o_vga_vs", 32'(o_vga_vs), 32'(exp_vs));
			end
			ph_h = (ph_h + 1) % 24;
			ph_v = (ph_v + 1) % 56;
			i_hs = ph_h >= 4;
			i_vs = ph_v >= 6;
		end
	end

	// ===================================================================
	// Stimulus tasks
	// ===================================================================

	task automatic send_word(input logic [IO_W-1:0] w);
		i_io_din = w;
		repeat (2) @(negedge clk_sys);
		i_io_clk = 1'b1;
		repeat (4) @(negedge clk_sys);
		i_io_clk = 1'b0;
		repeat (4) @(negedge clk_sys);
	endtask

	task automatic frame_command(input logic [7:0] cmd, input logic [IO_W-1:0] data);
		i_io_uio = 1'b1;
		@(negedge clk_sys);
		send_word({8'h00, cmd});
		send_word(data);
		i_io_uio = 1'b0;
		repeat (3) @(negedge clk_sys);
	endtask

	// Let valid samples leave the pipeline before settings move
	task automatic pause_audio_checks();
		chk_en = 1'b0;
		repeat (4) @(negedge clk_sys);
	endtask

	task automatic set_mode(input int mix, input logic sgn);
		pause_audio_checks();
		i_mix = mix_e'(mix);
		i_core_signed = sgn;
		chk_en = 1'b1;
	endtask

	task automatic set_volume(input logic [VOL_W-1:0] v);
		pause_audio_checks();
		frame_command(CMD_VOL, 16'(v));
		exp_vol = v;
		chk_en = 1'b1;
	endtask

	task automatic drive_random(input int n);
		logic [31:0] a;
		logic [31:0] b;
		repeat (n) begin
			a = $random(seed);
			b = $random(seed);
			i_core_l = a[15:0];
			i_core_r = a[31:16];
			i_pcm_l = b[15:0];
			i_pcm_r = b[31:16];
			@(negedge clk_sys);
		end
	endtask

	task automatic hold_pair(input logic [15:0] cl, input logic [15:0] cr,
			input logic [15:0] pl, input logic [15:0] pr,
			input logic [15:0] exp_l, input logic [15:0] exp_r);
		i_core_l = cl;
		i_core_r = cr;
		i_pcm_l = pl;
		i_pcm_r = pr;
		repeat (5) @(negedge clk_sys);
		check_value("o_audio_l", 32'(o_audio_l), 32'(exp_l));
		check_value("o_audio_r", 32'(o_audio_r), 32'(exp_r));
	endtask

	task automatic check_leds();
		logic [10:0] e;
		for (int k = 0; k < 32; k++) begin
			i_led_user = k[0];
			i_led_power = k[2:1];
			i_led_disk = k[4:3];
			@(negedge clk_sys);
			e = led_ref(i_led_user, i_led_power, i_led_disk, exp_ovr, exp_st);
			check_value("o_led", 32'(o_led), 32'(e[7:0]));
			check_value("lamps", 32'({o_lamp_user, o_lamp_power, o_lamp_disk}), 32'(e[10:8]));
		end
	endtask

	// Flags read by the sync process change away from its edge
	task automatic set_sync_check(input bit chk, input logic csync);
		@(posedge clk_sys);
		sync_chk = chk;
		exp_csync = csync;
		@(negedge clk_sys);
	endtask

	task automatic wait_sync(output bit ok);
		int n;
		n = 0;
		while (sync_good < 60 && n < 400) begin
			@(posedge clk_sys);
			n++;
		end
		ok = sync_good >= 60;
		if (!ok) begin
			timeouts++;
			$display("Timeout: VGA sync outputs did not settle within 400 cycles");
		end
		@(negedge clk_sys);
	endtask

	task automatic wait_user_button(input logic level, output bit ok);
		int n;
		n = 0;
		while (o_btn_user !== level && n < 48) begin
			@(negedge clk_sys);
			n++;
		end
		ok = o_btn_user === level;
		if (!ok) begin
			timeouts++;
			$display("Timeout: o_btn_user did not reach %0d within 48 cycles", level);
		end
	endtask

	// ===================================================================
	// Test sequence
	// ===================================================================

	task automatic run_tests();
		bit ok;
		// Random audio over volume, signedness and mix
		for (int v = 0; v <= 10; v += 5) begin
			set_volume(VOL_W'(v));
			for (int s = 0; s < 2; s++) begin
				for (int m = 0; m < 4; m++) begin
					set_mode(m, s[0]);
					drive_random(16);
				end
			end
		end

		// Saturation and mute
		set_mode(0, 1'b1);
		set_volume(5'd0);
		hold_pair(16'h7fff, 16'h8000, 16'h7fff, 16'h8000, 16'h7fff, 16'h8000);
		hold_pair(16'h8000, 16'h7fff, 16'h8000, 16'h7fff, 16'h8000, 16'h7fff);
		set_volume(5'h10);
		drive_random(12);
		check_value("o_audio_l", 32'(o_audio_l), 32'd0);
		check_value("o_audio_r", 32'(o_audio_r), 32'd0);
		set_volume(5'd2);

		// LED mapping before and after an override
		check_leds();
		frame_command(CMD_LED, 16'h3521);
		exp_ovr = 8'h35;
		exp_st = 8'h21;
		check_leds();

		// Sync polarity in separate and composite mode
		wait_sync(ok);
		if (!ok) return;
		set_sync_check(1'b1, 1'b0);
		drive_random(120);
		set_sync_check(1'b0, 1'b0);
		frame_command(CMD_CFG, 16'h0008);
		set_sync_check(1'b0, 1'b1);
		wait_sync(ok);
		if (!ok) return;
		set_sync_check(1'b1, 1'b1);
		drive_random(120);

		// Buttons
		i_btn_user_n = 1'b0;
		wait_user_button(1'b1, ok);
		if (!ok) return;
		i_btn_user_n = 1'b1;
		wait_user_button(1'b0, ok);
		if (!ok) return;
		i_btn_osd_n = 1'b0;
		repeat (12) @(negedge clk_sys);
		i_btn_osd_n = 1'b1;
		repeat (64) begin
			@(negedge clk_sys);
			check_value("o_btn_osd", 32'(o_btn_osd), 32'd0);
		end

		// Words outside a frame and an unknown command
		send_word(16'h0026);
		send_word(16'h0010);
		drive_random(16);
		check_leds();
		frame_command(8'h42, 16'h0000);
		drive_random(16);
		check_leds();

		// Back-to-back frames
		frame_command(CMD_LED, 16'h0f0a);
		exp_ovr = 8'h0f;
		exp_st = 8'h0a;
		set_volume(5'd3);
		drive_random(16);
		check_leds();
		pause_audio_checks();
	endtask

	initial begin
		seed = 32'hda53;
		checks = 0;
		errors = 0;
		timeouts = 0;
		exp_vol = '0;
		exp_ovr = 8'h00;
		exp_st = 8'h00;
		exp_csync = 1'b0;
		chk_en = 1'b1;
		sync_chk = 1'b0;
		sync_good = 0;
		resetd = 1'b1;
		i_io_uio = 1'b0;
		i_io_clk = 1'b0;
		i_io_din = '0;
		i_core_l = '0;
		i_core_r = '0;
		i_pcm_l = '0;
		i_pcm_r = '0;
		i_core_signed = 1'b0;
		i_mix = MIX_NONE;
		i_led_user = 1'b0;
		i_led_power = 2'b00;
		i_led_disk = 2'b00;
		i_btn_user_n = 1'b1;
		i_btn_osd_n = 1'b1;
		repeat (3) @(negedge clk_sys);
		resetd = 1'b0;
		run_tests();
		$display("%0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// File: sys_core.f
common/sys_pkg.sv
hw/cmd_decoder.sv
audio_mix/audio_mixer.sv
hw/sync_polarity.sv
hw/vga_sync.sv
hw/button_debounce.sv
hw/led_ctrl.sv
hw/sys_core.sv
tests/tb_sys_core.sv

// File: run_sim.sh
#!/bin/sh
# Build the sys_core testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_sys_core -f sys_core.f -o tb_sys_core
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_sys_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
	echo "Simulation reported failures"
	exit 1
fi

echo "Simulation finished without failures"
exit 0
